//--- Makefile
VERILATOR   ?= verilator
FILELIST    ?= stream_buffer.f
RTL_TOP     ?= stream_buffer
TB_TOP      ?= stream_buffer_tb
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
LINT_FLAGS  ?= --lint-only --timing
BUILD_FLAGS ?= --binary --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/fifo_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_buffer_cfg.svh"

module fifo_mem (
  input  wire                     clk,
  input  wire                     we,
  input  wire stream_buffer_pkg::addr_t waddr,
  input  wire stream_buffer_pkg::word_t wdata,
  input  wire stream_buffer_pkg::addr_t raddr,
  output stream_buffer_pkg::word_t rdata
);

  import stream_buffer_pkg::*;

  localparam int DEPTH = 1 << `SB_ADDR_WIDTH;

  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Combinational read at the read pointer
  always_comb begin
    rdata = mem[raddr];
  end

endmodule

`default_nettype wire

//--- design/simple_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_buffer_cfg.svh"

module simple_fifo (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire                         clear,

  input  wire                         din_valid,
  input  wire stream_buffer_pkg::word_t din,
  output logic                        din_ready,

  output logic                        dout_valid,
  output stream_buffer_pkg::word_t    dout,
  input  wire                         dout_ready,

  output stream_buffer_pkg::fifo_status_t status
);

  import stream_buffer_pkg::*;

  addr_t  wptr_q;
  addr_t  rptr_q;
  logic   full_q;
  logic   empty_q;
  count_t count_q;
  count_t count_d;
  logic   afull_q;
  logic   active_q;  // Low until the first edge after reset release

  logic enque;
  logic deque;

  assign enque = din_valid & din_ready;
  assign deque = dout_valid & dout_ready;

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////

  fifo_mem u_mem (
    .clk   (clk),
    .we    (enque),
    .waddr (wptr_q),
    .wdata (din),
    .raddr (rptr_q),
    .rdata (dout)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else if (clear) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (enque) wptr_q <= wptr_q + addr_t'(1);
      if (deque) rptr_q <= rptr_q + addr_t'(1);
    end
  end

  ////////////////////////////////////////
  // Full and empty
  ////////////////////////////////////////

  // Only an unbalanced transaction can change either flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full_q  <= 1'b0;
      empty_q <= 1'b1;
    end else if (clear) begin
      full_q  <= 1'b0;
      empty_q <= 1'b1;
    end else if (enque ^ deque) begin
      full_q  <= enque && ((wptr_q + addr_t'(1)) == rptr_q);
      empty_q <= deque && ((rptr_q + addr_t'(1)) == wptr_q);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) active_q <= 1'b0;
    else         active_q <= 1'b1;
  end

  ////////////////////////////////////////
  // Occupancy and watermark
  ////////////////////////////////////////

  always_comb begin
    count_d = count_q;
    if (enque && !deque)      count_d = count_q + count_t'(1);
    else if (!enque && deque) count_d = count_q - count_t'(1);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
      afull_q <= 1'b0;
    end else if (clear) begin
      count_q <= '0;
      afull_q <= 1'b0;
    end else begin
      count_q <= count_d;
      afull_q <= count_d >= count_t'(`SB_AFULL_LEVEL); // Tracks the count
    end
  end

  assign din_ready  = ~full_q & active_q;
  assign dout_valid = ~empty_q;

  assign status.item_count  = count_q;
  assign status.full        = full_q;
  assign status.empty       = empty_q;
  assign status.almost_full = afull_q;

endmodule

`default_nettype wire

//--- design/skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buffer (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire                         clear,

  input  wire                         in_valid,
  input  wire stream_buffer_pkg::word_t in_data,
  output logic                        in_ready,

  output logic                        out_valid,
  output stream_buffer_pkg::word_t    out_data,
  input  wire                         out_ready
);

  import stream_buffer_pkg::*;

  logic  main_valid_q;
  logic  main_valid_d;
  word_t main_data_q;
  logic  spare_valid_q;
  logic  spare_valid_d;
  word_t spare_data_q;
  logic  ready_q;

  logic accept;
  logic main_load;

  assign accept    = in_valid & ready_q;
  assign main_load = !main_valid_q || out_ready; // Main entry empty or draining

  ////////////////////////////////////////
  // Entry occupancy
  ////////////////////////////////////////

  always_comb begin
    main_valid_d  = main_valid_q;
    spare_valid_d = spare_valid_q;
    if (main_load) begin
      if (spare_valid_q) begin
        // Older word in the spare goes first
        main_valid_d  = 1'b1;
        spare_valid_d = 1'b0;
      end else begin
        main_valid_d = accept;
      end
    end else if (accept) begin
      spare_valid_d = 1'b1; // Downstream stalled, park the word
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      main_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
      ready_q       <= 1'b0;
    end else if (clear) begin
      main_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
      ready_q       <= 1'b0;
    end else begin
      main_valid_q  <= main_valid_d;
      spare_valid_q <= spare_valid_d;
      ready_q       <= !spare_valid_d; // Room while the spare is free
    end
  end

  ////////////////////////////////////////
  // Payload
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (main_load) begin
      main_data_q <= spare_valid_q ? spare_data_q : in_data;
    end
    if (accept && !main_load) begin
      spare_data_q <= in_data;
    end
  end

  assign in_ready  = ready_q;
  assign out_valid = main_valid_q;
  assign out_data  = main_data_q;

endmodule

`default_nettype wire

//--- design/stream_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_buffer (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire                         clear,

  input  wire                         in_valid,
  input  wire stream_buffer_pkg::word_t in_data,
  output logic                        in_ready,

  output logic                        out_valid,
  output stream_buffer_pkg::word_t    out_data,
  input  wire                         out_ready,

  output stream_buffer_pkg::fifo_status_t status
);

  import stream_buffer_pkg::*;

  // Skid buffer to FIFO
  logic  skid_valid;
  word_t skid_data;
  logic  fifo_ready;

  skid_buffer u_skid (
    .clk       (clk),
    .arst_n    (arst_n),
    .clear     (clear),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (skid_valid),
    .out_data  (skid_data),
    .out_ready (fifo_ready)
  );

  simple_fifo u_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .clear      (clear),
    .din_valid  (skid_valid),
    .din        (skid_data),
    .din_ready  (fifo_ready),
    .dout_valid (out_valid),
    .dout       (out_data),
    .dout_ready (out_ready),
    .status     (status)
  );

endmodule

`default_nettype wire

//--- design/stream_buffer_cfg.svh
`ifndef STREAM_BUFFER_CFG_SVH
`define STREAM_BUFFER_CFG_SVH

////////////////////////////////////////
// Data path
////////////////////////////////////////

`define SB_DATA_WIDTH 32 // Bits per stream word

////////////////////////////////////////
// FIFO sizing
////////////////////////////////////////

// Depth is 2**SB_ADDR_WIDTH words
`define SB_ADDR_WIDTH 4

// almost_full is high at or above this occupancy
`define SB_AFULL_LEVEL 12

`endif

//--- design/stream_buffer_pkg.sv
`default_nettype none

`include "stream_buffer_cfg.svh"

package stream_buffer_pkg;

  typedef logic [`SB_DATA_WIDTH-1:0] word_t;  // One stream word
  typedef logic [`SB_ADDR_WIDTH-1:0] addr_t;  // FIFO pointer

  // Occupancy, one extra bit so a full FIFO fits
  typedef logic [`SB_ADDR_WIDTH:0] count_t;

  ////////////////////////////////////////
  // FIFO status
  ////////////////////////////////////////

  typedef struct packed {
    count_t item_count;
    logic   full;
    logic   empty;
    logic   almost_full;  // item_count at or above the watermark
  } fifo_status_t;

endpackage

`default_nettype wire

//--- dv/stream_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "stream_buffer_cfg.svh"

module stream_buffer_tb;

  import stream_buffer_pkg::*;

  localparam int DEPTH           = 1 << `SB_ADDR_WIDTH;
  localparam int CAPACITY        = DEPTH + 2; // FIFO plus both skid entries
  localparam int RANDOM_CYCLES   = 2000;
  localparam int CLEAR_AT        = RANDOM_CYCLES / 2;
  localparam int FILL_CYCLES     = CAPACITY + 12;
  localparam int OVERHEAD_CYCLES = 200; // Reset, probes, idle waits and drains
  localparam int TIMEOUT_CYCLES  = 2 * (RANDOM_CYCLES + FILL_CYCLES + OVERHEAD_CYCLES);

  logic         clk;
  logic         arst_n;
  logic         clear;
  logic         in_valid;
  word_t        in_data;
  logic         in_ready;
  logic         out_valid;
  word_t        out_data;
  logic         out_ready;
  fifo_status_t status;

  integer seed;
  int     cycle_count;
  word_t  model_q[$]; // Words accepted and not yet delivered

  stream_buffer i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .clear     (clear),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready),
    .status    (status)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $fatal(1, "Run stopped by the cycle limit");
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check(input logic ok, input string what);
    assert (ok) else begin
      $display("Fail at %0t: %s", $time, what);
      $display("** FAIL **");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  // Handshakes sampled half a cycle before the rising edge
  task automatic step();
    logic  in_fire;
    logic  out_fire;
    logic  clr;
    word_t in_word;
    word_t out_word;
    word_t expected;
    in_fire  = in_valid && in_ready;
    out_fire = out_valid && out_ready;
    clr      = clear;
    in_word  = in_data;
    out_word = out_data;
    @(posedge clk);
    if (out_fire) begin
      check(model_q.size() != 0, "output transfer while no word was expected");
      if (model_q.size() != 0) begin
        expected = model_q.pop_front();
        check(out_word == expected,
              $sformatf("out_data %h, expected %h", out_word, expected));
      end
    end
    if (clr) model_q.delete(); // A word offered at the clear edge is dropped too
    else if (in_fire) model_q.push_back(in_word);
    @(negedge clk);
  endtask

  task automatic drain();
    in_valid  = 1'b0;
    out_ready = 1'b1;
    while (model_q.size() != 0) step();
    check(!out_valid, "out_valid high with nothing left to deliver");
    check(status.empty && status.item_count == '0, "FIFO not empty after drain");
  endtask

  task automatic idle_status();
    int expected;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    repeat (3) step();
    // Skid entries have moved on unless the FIFO is full
    expected = (model_q.size() > DEPTH) ? DEPTH : model_q.size();
    check(int'(status.item_count) == expected,
          $sformatf("item_count %0d, expected %0d", status.item_count, expected));
    check(status.empty == (expected == 0), "empty flag disagrees with occupancy");
    check(status.almost_full == (expected >= `SB_AFULL_LEVEL),
          "almost_full disagrees with occupancy");
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int accepted;
    seed      = 32'h83dacd2a;
    arst_n    = 1'b0;
    clear     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    accepted  = 0;

    repeat (5) begin
      @(negedge clk);
      check(!in_ready && !out_valid, "in_ready or out_valid high during reset");
      check(status.empty && !status.full && !status.almost_full, "flags wrong during reset");
      check(status.item_count == '0, "item_count not zero during reset");
    end
    arst_n = 1'b1;
    check(!in_ready, "in_ready high before the first edge after reset");
    step();

    // Latency into an empty buffer
    in_valid = 1'b1;
    in_data  = word_t'($random(seed));
    check(in_ready && !out_valid, "buffer not ready and empty after reset");
    step();
    in_valid = 1'b0;
    check(!out_valid, "out_valid high right after the accepting edge");
    step(); // FIFO write from the skid main entry
    check(out_valid, "accepted word not visible at the output");
    drain();

    // Back-pressure fill
    in_valid  = 1'b1;
    out_ready = 1'b0;
    repeat (FILL_CYCLES) begin
      in_data = word_t'($random(seed));
      if (in_ready) accepted++;
      step();
    end
    check(accepted == CAPACITY,
          $sformatf("accepted %0d words under back-pressure, expected %0d", accepted, CAPACITY));
    check(!in_ready, "in_ready high with every entry occupied");
    check(status.full && status.almost_full, "full or almost_full low when filled");
    idle_status();
    drain();

    // Random traffic with a slow sink in the first half and a clear in the middle
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      in_valid = ($random(seed) & 3) != 0;
      in_data  = word_t'($random(seed));
      if (i < CLEAR_AT) out_ready = ($random(seed) & 3) == 0;
      else              out_ready = ($random(seed) & 3) != 0;
      clear = (i == CLEAR_AT);
      step();
      if (i == CLEAR_AT) begin
        clear = 1'b0;
        check(!out_valid && !in_ready, "out_valid or in_ready high after clear");
        check(status.item_count == '0 && status.empty, "FIFO not empty after clear");
        check(!status.full && !status.almost_full, "full or almost_full high after clear");
      end
      if (i == CLEAR_AT / 2) idle_status();
    end
    idle_status();
    drain();

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- stream_buffer.f
+incdir+design
design/stream_buffer_pkg.sv
design/fifo_mem.sv
design/simple_fifo.sv
design/skid_buffer.sv
design/stream_buffer.sv
dv/stream_buffer_tb.sv
